// ==== soc_tests.txt ====
# test op master addr data sel expected (hex except test and master)
# W write, R read and compare, C both masters, G gpio_in, O gpio_out, I irq_o, T timer wait
1 W 0 20000010 11223344 f 00000000
1 R 0 20000010 00000000 f 11223344
1 W 0 20000010 aabbccdd 5 00000000
1 R 0 20000010 00000000 f 11bb33dd
1 W 0 20000010 55667788 8 00000000
1 R 0 20000010 00000000 f 55bb33dd
1 W 0 20000014 cafef00d f 00000000
1 W 0 20000014 00001234 3 00000000
1 R 0 20000014 00000000 f cafe1234
1 R 0 20001010 00000000 f 55bb33dd
2 C 0 20000100 20000104 f 00000000
2 C 0 20000200 20000208 f 00000000
3 R 0 00000000 00000000 f abadface
3 R 1 40000020 00000000 f abadface
3 R 0 e0000004 00000000 f abadface
3 W 1 40000000 12345678 f 00000000
4 R 0 80001000 00000000 f 58343031
4 W 0 80001008 ffffffff f 00000000
4 O 0 00000000 00000000 0 00003fff
4 R 1 80001008 00000000 f 00003fff
4 G 0 00000000 00000ab5 0 00000000
4 R 0 80001004 00000000 f 00000ab5
5 W 0 8000100c 00000003 f 00000000
5 R 0 8000100c 00000000 f 00000000
5 G 0 00000000 0000154a 0 00000000
5 I 0 00000000 00000000 0 00000000
5 R 0 8000100c 00000000 f 00000001
5 W 0 80001010 00000001 f 00000000
5 I 0 00000000 00000000 0 00000001
5 W 0 8000100c 00000001 f 00000000
5 I 0 00000000 00000000 0 00000000
5 R 0 8000100c 00000000 f 00000000
6 W 0 80001010 00000002 f 00000000
6 W 0 80001018 00000010 f 00000000
6 W 0 80001014 00000001 f 00000000
6 T 0 00000000 00000040 0 00000000
6 I 0 00000000 00000000 0 00000002
6 R 0 8000101c 00000000 f 00000010
6 R 0 80001014 00000000 f 00000000

// ==== sim.f ====
+incdir+.
bus_pkg.sv
csr_pkg.sv
bus_switch.sv
sram_slave.sv
csr_bridge.sv
sysctl_regs.sv
soc_top.sv
tb_soc.sv

// ==== Bender.yml ====
package:
  name: soc_bus

dependencies: {}

sources:
  # Packages
  - bus_pkg.sv
  - csr_pkg.sv
  # RTL
  - bus_switch.sv
  - sram_slave.sv
  - csr_bridge.sv
  - sysctl_regs.sv
  - soc_top.sv
  # Testbench
  - target: test
    include_dirs:
      - .
    files:
      - tb_soc.sv

// ==== tb_bus_master.svh ====
// Bus master tasks for the SoC testbench with word access per master, bounded waits and LFSR
`ifndef TB_BUS_MASTER_SVH
`define TB_BUS_MASTER_SVH

	// ------------------------------------------------------------------------
	// Random data
	// ------------------------------------------------------------------------

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// One LFSR step per data bit
	function automatic logic [31:0] random_word();
		logic [31:0] w;
		for (int i = 0; i < 32; i++) begin
			w[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
		return w;
	endfunction

	// ------------------------------------------------------------------------
	// Bus access
	// ------------------------------------------------------------------------

	// Hold the request until ack and drop it after
	task automatic bus_cycle(input int m, input logic we, input logic [31:0] adr,
			input logic [31:0] dat, input logic [3:0] sel, output logic [31:0] rdata);
		bus_pkg::bus_req_t req;
		bus_pkg::bus_rsp_t rsp;
		int waited;
		req = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
		rsp = '0;
		rdata = '0;
		waited = 0;
		@(posedge sys_clk);
		if (m == 0) begin
			m0_req <= req;
		end else begin
			m1_req <= req;
		end
		// Ack sampled mid-cycle
		while (!rsp.ack && waited < ACK_TIMEOUT) begin
			@(negedge sys_clk);
			rsp = (m == 0) ? m0_rsp : m1_rsp;
			waited++;
		end
		if (rsp.ack) begin
			rdata = rsp.dat;
		end else begin
			$display("Timeout: master %0d got no ack within %0d cycles at address %h",
				m, ACK_TIMEOUT, adr);
			test_errs++;
		end
		@(posedge sys_clk);
		if (m == 0) begin
			m0_req <= '0;
		end else begin
			m1_req <= '0;
		end
	endtask

	task automatic write_word(input int m, input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel);
		logic [31:0] unused;
		bus_cycle(m, 1'b1, adr, dat, sel, unused);
	endtask

	task automatic read_word(input int m, input logic [31:0] adr, output logic [31:0] rdata);
		bus_cycle(m, 1'b0, adr, 32'h0, 4'hf, rdata);
	endtask

	// Bounded wait for the timer interrupt line
	task automatic wait_timer_irq(input int limit);
		int waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		// Line sampled mid-cycle
		while (!seen && waited < limit) begin
			@(negedge sys_clk);
			seen = irq[csr_pkg::IRQ_TIMER];
			waited++;
		end
		if (!seen) begin
			$display("Timeout: timer interrupt did not rise within %0d cycles", limit);
			test_errs++;
		end
	endtask

`endif

// ==== tb_soc.sv ====
// Testbench for the SoC bus backbone, stimulus and expected values from a vector file
`default_nettype none

module tb_soc;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ACK_TIMEOUT = 50;
	localparam logic [31:0] LFSR_SEED = 32'h6fef4f29;

	logic sys_clk;
	logic rst1;
	bus_pkg::bus_req_t m0_req;
	bus_pkg::bus_req_t m1_req;
	bus_pkg::bus_rsp_t m0_rsp;
	bus_pkg::bus_rsp_t m1_rsp;
	logic [12:0] gpio_in;
	logic [13:0] gpio_out;
	logic [1:0] irq;
	logic [31:0] lfsr_state;
	// Error count of the running test
	int test_errs;
	int tests_passed;
	int tests_failed;

	`include "tb_bus_master.svh"

	soc_top uut (
		.sys_clk    (sys_clk),
		.rst1       (rst1),
		.m0_req_i   (m0_req),
		.m0_rsp_o   (m0_rsp),
		.m1_req_i   (m1_req),
		.m1_rsp_o   (m1_rsp),
		.gpio_in_i  (gpio_in),
		.gpio_out_o (gpio_out),
		.irq_o      (irq)
	);

	// 50 MHz
	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// One line per finished test
	task automatic report_test(input int num);
		if (test_errs == 0) begin
			$display("Test %0d passed", num);
			tests_passed++;
		end else begin
			$display("Test %0d failed with %0d errors", num, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	// ------------------------------------------------------------------------
	// Vector runner
	// ------------------------------------------------------------------------
	initial begin
		int fd;
		int cur_test;
		int num;
		int m;
		int n;
		string line;
		string op;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] exp_val;
		logic [3:0] sel;
		logic [31:0] rd0;
		logic [31:0] rd1;
		logic [31:0] w0;
		logic [31:0] w1;
		rst1 = 1'b0;
		m0_req = '0;
		m1_req = '0;
		gpio_in = '0;
		lfsr_state = LFSR_SEED;
		test_errs = 0;
		tests_passed = 0;
		tests_failed = 0;
		cur_test = -1;
		repeat (5) @(posedge sys_clk);
		rst1 <= 1'b1;
		fd = $fopen("soc_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open soc_tests.txt for reading");
			tests_failed++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Skip comments and blank lines
				if (line.len() < 2 || line[0] == "#") begin
					continue;
				end
				n = $sscanf(line, "%d %s %d %h %h %h %h", num, op, m, adr, dat, sel, exp_val);
				if (n != 7) begin
					$display("Malformed line in soc_tests.txt: %s", line);
					tests_failed++;
					continue;
				end
				if (num != cur_test) begin
					if (cur_test >= 0) begin
						report_test(cur_test);
					end
					cur_test = num;
				end
				case (op)
					"W": write_word(m, adr, dat, sel);
					"R": begin
						read_word(m, adr, rd0);
						if (rd0 !== exp_val) begin
							$display("CHECK FAILED m%0d_rsp_o.dat at %h expected %h got %h",
								m, adr, exp_val, rd0);
							test_errs++;
						end
					end
					// Both masters in the same cycle, m1 address in the data column
					"C": begin
						w0 = random_word();
						w1 = random_word();
						fork
							write_word(0, adr, w0, 4'hf);
							write_word(1, dat, w1, 4'hf);
						join
						fork
							read_word(0, adr, rd0);
							read_word(1, dat, rd1);
						join
						if (rd0 !== w0) begin
							$display("CHECK FAILED m0_rsp_o.dat expected %h got %h", w0, rd0);
							test_errs++;
						end
						if (rd1 !== w1) begin
							$display("CHECK FAILED m1_rsp_o.dat expected %h got %h", w1, rd1);
							test_errs++;
						end
					end
					"G": begin
						@(posedge sys_clk);
						gpio_in <= dat[12:0];
						// Two sync stages plus change detect
						repeat (4) @(posedge sys_clk);
					end
					"O": begin
						@(negedge sys_clk);
						if (gpio_out !== exp_val[13:0]) begin
							$display("CHECK FAILED gpio_out_o expected %h got %h",
								exp_val[13:0], gpio_out);
							test_errs++;
						end
					end
					"I": begin
						@(negedge sys_clk);
						if (irq !== exp_val[1:0]) begin
							$display("CHECK FAILED irq_o expected %h got %h", exp_val[1:0], irq);
							test_errs++;
						end
					end
					"T": wait_timer_irq(int'(dat));
					default: begin
						$display("Unknown operation %s in soc_tests.txt", op);
						test_errs++;
					end
				endcase
			end
			if (cur_test >= 0) begin
				report_test(cur_test);
			end
			$fclose(fd);
		end
		if (tests_passed == 0 && tests_failed == 0) begin
			$display("No test vectors were run");
			tests_failed++;
		end
		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== soc_top.sv ====
// SoC top level: bus switch, on-chip SRAM, CSR bridge and system controller
`default_nettype none

module soc_top #(
	parameter int unsigned SRAM_ADR_W = 10,
	parameter int unsigned GPIO_IN_W  = 13,
	parameter int unsigned GPIO_OUT_W = 14,
	parameter logic [csr_pkg::CSR_BANK_W-1:0] SYSCTL_BANK = 4'h1,
	// "X401"
	parameter logic [31:0] SYSTEM_ID  = 32'h58343031
) (
	input  wire logic                  sys_clk,
	input  wire logic                  rst1,
	// Processor data port
	input  wire bus_pkg::bus_req_t     m0_req_i,
	output bus_pkg::bus_rsp_t          m0_rsp_o,
	// DMA port
	input  wire bus_pkg::bus_req_t     m1_req_i,
	output bus_pkg::bus_rsp_t          m1_rsp_o,
	// GPIO and interrupts
	input  wire logic [GPIO_IN_W-1:0]  gpio_in_i,
	output logic [GPIO_OUT_W-1:0]      gpio_out_o,
	output logic [1:0]                 irq_o
);

	// Slave ports of the switch
	bus_pkg::bus_req_t sram_req;
	bus_pkg::bus_rsp_t sram_rsp;
	bus_pkg::bus_req_t csrbrg_req;
	bus_pkg::bus_rsp_t csrbrg_rsp;

	// CSR bus
	csr_pkg::csr_req_t csr_req;
	logic [31:0] csr_rdata_sysctl;

	// -------------------------------------------------------------------------
	// Bus switch
	// -------------------------------------------------------------------------
	bus_switch u_switch (
		.sys_clk    (sys_clk),
		.rst1       (rst1),
		.m0_req_i   (m0_req_i),
		.m1_req_i   (m1_req_i),
		.m0_rsp_o   (m0_rsp_o),
		.m1_rsp_o   (m1_rsp_o),
		.sram_req_o (sram_req),
		.csr_req_o  (csrbrg_req),
		.sram_rsp_i (sram_rsp),
		.csr_rsp_i  (csrbrg_rsp)
	);

	// SRAM, 0x20000000
	sram_slave #(
		.SRAM_ADR_W (SRAM_ADR_W)
	) u_sram (
		.sys_clk (sys_clk),
		.rst1    (rst1),
		.req_i   (sram_req),
		.rsp_o   (sram_rsp)
	);

	// CSR bridge, 0x80000000
	csr_bridge u_csrbrg (
		.sys_clk     (sys_clk),
		.rst1        (rst1),
		.bus_req_i   (csrbrg_req),
		.bus_rsp_o   (csrbrg_rsp),
		.csr_o       (csr_req),
		// OR of all bank read words, only sysctl fitted
		.csr_rdata_i (csr_rdata_sysctl)
	);

	// -------------------------------------------------------------------------
	// System controller
	// -------------------------------------------------------------------------
	sysctl_regs #(
		.SYSCTL_BANK (SYSCTL_BANK),
		.GPIO_IN_W   (GPIO_IN_W),
		.GPIO_OUT_W  (GPIO_OUT_W),
		.SYSTEM_ID   (SYSTEM_ID)
	) u_sysctl (
		.sys_clk     (sys_clk),
		.rst1        (rst1),
		.csr_i       (csr_req),
		.csr_rdata_o (csr_rdata_sysctl),
		.gpio_in_i   (gpio_in_i),
		.gpio_out_o  (gpio_out_o),
		.irq_o       (irq_o)
	);

endmodule

`default_nettype wire

// ==== sysctl_regs.sv ====
// System controller CSR bank: ID, GPIO, interrupt pending and mask, one timer
`default_nettype none

module sysctl_regs #(
	parameter logic [csr_pkg::CSR_BANK_W-1:0] SYSCTL_BANK = 4'h1,
	parameter int unsigned GPIO_IN_W  = 13,
	parameter int unsigned GPIO_OUT_W = 14,
	parameter logic [31:0] SYSTEM_ID  = 32'h58343031
) (
	input  wire logic                  sys_clk,
	input  wire logic                  rst1,
	input  wire csr_pkg::csr_req_t     csr_i,
	output logic [31:0]                csr_rdata_o,
	input  wire logic [GPIO_IN_W-1:0]  gpio_in_i,
	output logic [GPIO_OUT_W-1:0]      gpio_out_o,
	output logic [1:0]                 irq_o
);

	logic bank_hit;
	logic wr;
	logic [csr_pkg::CSR_REG_W-1:0] reg_adr;
	logic [GPIO_IN_W-1:0] gpio_meta_q;
	logic [GPIO_IN_W-1:0] gpio_sync_q;
	logic [GPIO_IN_W-1:0] gpio_last_q;
	logic [GPIO_OUT_W-1:0] gpio_out_q;
	logic [1:0] pend_q;
	logic [1:0] mask_q;
	logic [1:0] pend_set;
	logic tmr_en_q;
	logic tmr_ar_q;
	logic tmr_hit;
	logic [31:0] tmr_cmp_q;
	logic [31:0] tmr_cnt_q;
	logic [31:0] rd_mux;
	logic [31:0] rdata_q;

	// Bank decode
	assign bank_hit = csr_i.adr[csr_pkg::CSR_ADR_W-1 -: csr_pkg::CSR_BANK_W] == SYSCTL_BANK;
	assign reg_adr  = csr_i.adr[csr_pkg::CSR_REG_W-1:0];
	assign wr       = bank_hit & csr_i.we;

	// GPIO inputs
	// two sync stages, third flop for change detect
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			gpio_meta_q <= '0;
			gpio_sync_q <= '0;
			gpio_last_q <= '0;
		end else begin
			gpio_meta_q <= gpio_in_i;
			gpio_sync_q <= gpio_meta_q;
			gpio_last_q <= gpio_sync_q;
		end
	end

	// Timer reached compare
	assign tmr_hit = tmr_en_q & (tmr_cnt_q == tmr_cmp_q);

	always_comb begin
		pend_set = '0;
		pend_set[csr_pkg::IRQ_GPIO]  = |(gpio_sync_q ^ gpio_last_q);
		pend_set[csr_pkg::IRQ_TIMER] = tmr_hit;
	end

	// -------------------------------------------------------------------------
	// Interrupts and GPIO outputs
	// -------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			pend_q     <= '0;
			mask_q     <= '0;
			gpio_out_q <= '0;
		end else begin
			// Sticky, write-one-to-clear, a new event wins
			if (wr && reg_adr == csr_pkg::REG_IRQ_PEND) begin
				pend_q <= (pend_q & ~csr_i.dat[1:0]) | pend_set;
			end else begin
				pend_q <= pend_q | pend_set;
			end
			if (wr && reg_adr == csr_pkg::REG_IRQ_MASK) begin
				mask_q <= csr_i.dat[1:0];
			end
			if (wr && reg_adr == csr_pkg::REG_GPIO_OUT) begin
				gpio_out_q <= csr_i.dat[GPIO_OUT_W-1:0];
			end
		end
	end

	// -------------------------------------------------------------------------
	// Timer
	// -------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			tmr_en_q  <= 1'b0;
			tmr_ar_q  <= 1'b0;
			tmr_cmp_q <= '0;
			tmr_cnt_q <= '0;
		end else begin
			if (tmr_hit) begin
				// Restart, or stop with the count at compare
				if (tmr_ar_q) begin
					tmr_cnt_q <= '0;
				end else begin
					tmr_en_q <= 1'b0;
				end
			end else if (tmr_en_q) begin
				tmr_cnt_q <= tmr_cnt_q + 32'd1;
			end
			// Software write overrides the count
			if (wr) begin
				case (reg_adr)
					csr_pkg::REG_TIMER_CTRL: begin
						tmr_en_q <= csr_i.dat[csr_pkg::TMR_EN];
						tmr_ar_q <= csr_i.dat[csr_pkg::TMR_AR];
					end
					csr_pkg::REG_TIMER_CMP: tmr_cmp_q <= csr_i.dat;
					csr_pkg::REG_TIMER_CNT: tmr_cnt_q <= csr_i.dat;
					default: ;
				endcase
			end
		end
	end

	// Read mux
	always_comb begin
		rd_mux = '0;
		case (reg_adr)
			csr_pkg::REG_SYSID:    rd_mux = SYSTEM_ID;
			csr_pkg::REG_GPIO_IN:  rd_mux = 32'(gpio_sync_q);
			csr_pkg::REG_GPIO_OUT: rd_mux = 32'(gpio_out_q);
			csr_pkg::REG_IRQ_PEND: rd_mux = 32'(pend_q);
			csr_pkg::REG_IRQ_MASK: rd_mux = 32'(mask_q);
			csr_pkg::REG_TIMER_CTRL: begin
				rd_mux[csr_pkg::TMR_EN] = tmr_en_q;
				rd_mux[csr_pkg::TMR_AR] = tmr_ar_q;
			end
			csr_pkg::REG_TIMER_CMP: rd_mux = tmr_cmp_q;
			csr_pkg::REG_TIMER_CNT: rd_mux = tmr_cnt_q;
			default: rd_mux = '0;
		endcase
	end

	// Zero when another bank is addressed, keeps the OR bus clean
	always_ff @(posedge sys_clk) begin
		rdata_q <= bank_hit ? rd_mux : '0;
	end

	assign csr_rdata_o = rdata_q;
	assign gpio_out_o  = gpio_out_q;
	assign irq_o       = pend_q & mask_q;

endmodule

`default_nettype wire

// ==== csr_bridge.sv ====
// Bus to CSR bridge: one CSR cycle per bus access, acks with the bank read word
`default_nettype none

module csr_bridge (
	input  wire logic              sys_clk,
	input  wire logic              rst1,
	// System bus side
	input  wire bus_pkg::bus_req_t bus_req_i,
	output bus_pkg::bus_rsp_t      bus_rsp_o,
	// CSR side
	output csr_pkg::csr_req_t      csr_o,
	input  wire logic [31:0]       csr_rdata_i
);

	typedef enum logic {
		S_IDLE,
		S_CSR
	} state_t;

	state_t state_q;
	logic start;
	logic ack_q;
	logic csr_we_q;
	logic [csr_pkg::CSR_ADR_W-1:0] csr_adr_q;
	logic [31:0] csr_dat_q;

	// Ignore the held request during its ack
	assign start = (state_q == S_IDLE) & bus_req_i.cyc & bus_req_i.stb & ~ack_q;

	// -------------------------------------------------------------------------
	// Sequencer
	// cycle 1 drives the CSR bus, cycle 2 acks
	// -------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			state_q  <= S_IDLE;
			ack_q    <= 1'b0;
			csr_we_q <= 1'b0;
		end else begin
			ack_q    <= 1'b0;
			// Write strobe for one cycle only
			csr_we_q <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (start) begin
						state_q  <= S_CSR;
						csr_we_q <= bus_req_i.we;
					end
				end
				S_CSR: begin
					state_q <= S_IDLE;
					ack_q   <= 1'b1;
				end
			endcase
		end
	end

	// Address and data, byte selects dropped
	always_ff @(posedge sys_clk) begin
		if (start) begin
			csr_adr_q <= bus_req_i.adr[csr_pkg::CSR_ADR_W+1:2];
			csr_dat_q <= bus_req_i.dat;
		end
	end

	assign csr_o = '{adr: csr_adr_q, we: csr_we_q, dat: csr_dat_q};
	// Bank read word already registered in the bank
	assign bus_rsp_o = '{dat: csr_rdata_i, ack: ack_q};

endmodule

`default_nettype wire

// ==== sram_slave.sv ====
// On-chip SRAM slave with byte-lane writes, registered read and one-cycle ack
`default_nettype none

module sram_slave #(
	parameter int unsigned SRAM_ADR_W = 10
) (
	input  wire logic              sys_clk,
	input  wire logic              rst1,
	input  wire bus_pkg::bus_req_t req_i,
	output bus_pkg::bus_rsp_t      rsp_o
);

	localparam int unsigned DEPTH = 2 ** SRAM_ADR_W;

	logic [31:0] mem [DEPTH];
	logic [SRAM_ADR_W-1:0] word_adr;
	logic access;
	logic ack_q;
	logic [31:0] rdata_q;

	// Word address, upper bits alias
	assign word_adr = req_i.adr[SRAM_ADR_W+1:2];
	// Not again in the ack cycle
	assign access   = req_i.cyc & req_i.stb & ~ack_q;

	// Memory array
	always_ff @(posedge sys_clk) begin
		if (access) begin
			if (req_i.we) begin
				for (int i = 0; i < 4; i++) begin
					if (req_i.sel[i]) begin
						mem[word_adr][8*i +: 8] <= req_i.dat[8*i +: 8];
					end
				end
			end
			// Read before write, old word on a write
			rdata_q <= mem[word_adr];
		end
	end

	// Ack one cycle after stb
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	assign rsp_o = '{dat: rdata_q, ack: ack_q};

endmodule

`default_nettype wire

// ==== bus_switch.sv ====
// Bus switch with two-master round-robin arbiter, slave decode and default responder
`default_nettype none

module bus_switch (
	input  wire logic              sys_clk,
	input  wire logic              rst1,
	// Masters
	input  wire bus_pkg::bus_req_t m0_req_i,
	input  wire bus_pkg::bus_req_t m1_req_i,
	output bus_pkg::bus_rsp_t      m0_rsp_o,
	output bus_pkg::bus_rsp_t      m1_rsp_o,
	// Slaves
	output bus_pkg::bus_req_t      sram_req_o,
	input  wire bus_pkg::bus_rsp_t sram_rsp_i,
	output bus_pkg::bus_req_t      csr_req_o,
	input  wire bus_pkg::bus_rsp_t csr_rsp_i
);

	// Grant state
	logic busy_q;
	// Owner of the most recent grant and of the bus while busy
	logic last_q;

	logic m0_want;
	logic m1_want;
	logic pick;
	logic cur;
	logic start;
	bus_pkg::bus_req_t sel_req;
	logic [bus_pkg::SLV_SEL_W-1:0] region;
	logic hit_sram;
	logic hit_csr;
	logic hit_none;
	logic dflt_ack_q;
	bus_pkg::bus_rsp_t slv_rsp;

	// -------------------------------------------------------------------------
	// Arbitration
	// -------------------------------------------------------------------------
	assign m0_want = m0_req_i.cyc & m0_req_i.stb;
	assign m1_want = m1_req_i.cyc & m1_req_i.stb;

	// With both asking the one not granted last time wins
	always_comb begin
		if (m0_want && m1_want) begin
			pick = ~last_q;
		end else begin
			pick = m1_want;
		end
	end

	// Idle bus grants in the same cycle
	assign cur     = busy_q ? last_q : pick;
	assign sel_req = cur ? m1_req_i : m0_req_i;
	assign start   = ~busy_q & sel_req.cyc & sel_req.stb;

	// Held until the owner's ack
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			busy_q <= 1'b0;
			// Master 0 first out of reset
			last_q <= 1'b1;
		end else if (start) begin
			busy_q <= 1'b1;
			last_q <= cur;
		end else if (busy_q && slv_rsp.ack) begin
			busy_q <= 1'b0;
		end
	end

	// -------------------------------------------------------------------------
	// Decode and forward
	// -------------------------------------------------------------------------
	assign region   = sel_req.adr[31 -: bus_pkg::SLV_SEL_W];
	assign hit_sram = (region == bus_pkg::SEL_SRAM);
	assign hit_csr  = (region == bus_pkg::SEL_CSR);
	assign hit_none = ~hit_sram & ~hit_csr;

	// Payload to both slaves and strobes to one
	always_comb begin
		sram_req_o     = sel_req;
		csr_req_o      = sel_req;
		sram_req_o.cyc = sel_req.cyc & hit_sram;
		sram_req_o.stb = sel_req.stb & hit_sram;
		csr_req_o.cyc  = sel_req.cyc & hit_csr;
		csr_req_o.stb  = sel_req.stb & hit_csr;
	end

	// Default responder
	// acks one cycle later and never twice in a row
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			dflt_ack_q <= 1'b0;
		end else begin
			dflt_ack_q <= sel_req.cyc & sel_req.stb & hit_none & ~dflt_ack_q;
		end
	end

	// Response of the addressed slave
	always_comb begin
		slv_rsp.dat = bus_pkg::UNMAPPED_DATA;
		slv_rsp.ack = dflt_ack_q;
		if (hit_sram) begin
			slv_rsp = sram_rsp_i;
		end else if (hit_csr) begin
			slv_rsp = csr_rsp_i;
		end
	end

	// Back to the owner only
	always_comb begin
		m0_rsp_o = '0;
		m1_rsp_o = '0;
		if (busy_q) begin
			if (cur) begin
				m1_rsp_o = slv_rsp;
			end else begin
				m0_rsp_o = slv_rsp;
			end
		end
	end

endmodule

`default_nettype wire

// ==== csr_pkg.sv ====
// CSR bus definitions: request format, bank field layout, system controller map
`default_nettype none

package csr_pkg;

	// CSR word address is {bank, register}
	localparam int CSR_ADR_W  = 14;
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W  = CSR_ADR_W - CSR_BANK_W;

	// One CSR cycle
	// we is a single-clock pulse
	typedef struct packed {
		logic [CSR_ADR_W-1:0] adr;
		logic                 we;
		logic [31:0]          dat;
	} csr_req_t;

	// System controller register words
	localparam logic [CSR_REG_W-1:0] REG_SYSID      = 10'd0;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_IN    = 10'd1;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_OUT   = 10'd2;
	localparam logic [CSR_REG_W-1:0] REG_IRQ_PEND   = 10'd3;
	localparam logic [CSR_REG_W-1:0] REG_IRQ_MASK   = 10'd4;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CTRL = 10'd5;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CMP  = 10'd6;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CNT  = 10'd7;

	// TIMER_CTRL bits
	localparam int TMR_EN = 0;	// Count enable
	localparam int TMR_AR = 1;	// Auto-restart

	// Interrupt bits, pending, mask and irq lines
	localparam int IRQ_GPIO  = 0;
	localparam int IRQ_TIMER = 1;
endpackage

`default_nettype wire

// ==== bus_pkg.sv ====
// System bus definitions: Wishbone-style request and response, address map
`default_nettype none

package bus_pkg;

	// -------------------------------------------------------------------------
	// Bus payloads
	// -------------------------------------------------------------------------

	// Master request
	// Held unchanged from cyc/stb rise until ack
	typedef struct packed {
		logic [31:0] adr;	// byte address
		logic [31:0] dat;	// Write data
		logic [3:0]  sel;	// Byte lanes, bit 0 is dat[7:0]
		logic        we;
		logic        cyc;
		logic        stb;
	} bus_req_t;

	// Slave response
	// Ack lasts one cycle, dat valid with it
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} bus_rsp_t;

	// -------------------------------------------------------------------------
	// Address map
	// -------------------------------------------------------------------------

	// Slave select is adr[31:29]
	localparam int SLV_SEL_W = 3;

	// On-chip SRAM at 0x20000000
	localparam logic [SLV_SEL_W-1:0] SEL_SRAM = 3'b001;
	// CSR bridge at 0x80000000
	localparam logic [SLV_SEL_W-1:0] SEL_CSR  = 3'b100;

	// Read data of every hole in the map
	localparam logic [31:0] UNMAPPED_DATA = 32'hABADFACE;

endpackage

`default_nettype wire
